// ==== sim.f ====
design/egress_pkg.sv
design/egress_if.sv
design/frame_queue_bank.sv
design/port_arbiter.sv
design/crc32_accum.sv
design/egress_scheduler.sv
design/egress_top.sv
sim/egress_sva.sv
sim/tb_egress.sv

// ==== Makefile ====
TOP := tb_egress

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation reported errors"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log || (echo "simulation ended without a result"; exit 1)

obj_dir/V$(TOP): sim.f $(wildcard design/*.sv sim/*.sv)
	verilator --binary --timing --assert -j 0 -f sim.f --top-module $(TOP) -Mdir obj_dir

lint:
	verilator --lint-only --timing -Wall -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== sim/tb_egress.sv ====
module tb_egress import egress_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_PORTS   = 4;
    localparam int QUEUE_DEPTH = 64;
    localparam int PW          = $clog2(NUM_PORTS);
    localparam int N_RAND      = 48;   // frames in the mixed phase
    localparam int MAX_LEN     = 16;
    localparam int WATCHDOG_CYCLES = (N_RAND + 2 * NUM_PORTS) * (MAX_LEN + 1) * 20 + 500;

    logic          clk;
    logic          rst_n;
    logic          in_wr;
    logic [PW-1:0] in_port;
    word_t         in_data;
    logic          sched_mode;
    logic          ready;
    word_t         out_data;
    logic          out_vld;
    logic          out_sop;
    logic          out_eop;
    logic [PW-1:0] out_port;
    logic          frame_err;

    //////////////////////////////////////////////////////////////////////
    // reference model state
    //////////////////////////////////////////////////////////////////////

    word_t exp_words [NUM_PORTS][$];
    int    exp_len   [NUM_PORTS][$];
    bit    exp_bad   [NUM_PORTS][$];
    int    pending   [NUM_PORTS];      // words of frames not yet out
    int    order_q   [$];              // expected grant order in ordered rounds
    int    last_served = NUM_PORTS - 1;
    int    frames_sent;
    int    frames_done;
    int    errors;
    int    frame_port;
    int    words_left;
    int    low_run;
    bit    in_frame;
    bit    err_window;
    bit    err_due;
    bit    toggle_ready;
    logic [31:0] lfsr = 32'h58f26254;

    egress_top #(.NUM_PORTS(NUM_PORTS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_dut (.*);

    always #4 clk = ~clk;

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic crc_t crc_word(crc_t c, word_t d);
        crc_t r;
        r = c;
        for (int i = 0; i < $bits(word_t); i++) begin
            r = (r >> 1) ^ (((r[0] ^ d[i]) == 1'b1) ? CRC_POLY : 32'h0);
        end
        return r;
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fail_check(input string what);
        errors++;
        $display("[FAIL] %0t: %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // one clock with ready high about 3 of 4 cycles in mixed traffic
    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        if (toggle_ready) begin
            rand_bits(2, r);
            ready <= |r[1:0];
        end
    endtask

    task automatic write_word(input int p, input word_t w);
        tick();
        in_wr   <= 1'b1;
        in_port <= PW'(p);
        in_data <= w;
    endtask

    task automatic send_frame(input int p, input int len, input prio_t pr, input bit bad);
        logic [31:0] hi;
        logic [31:0] lo;
        word_t       data [$];
        word_t       hdr;
        crc_t        c;
        c = CRC_INIT;
        for (int i = 0; i < len; i++) begin
            rand_bits(24, hi);
            rand_bits(24, lo);
            data.push_back({hi[23:0], lo[23:0]});
            c = crc_word(c, data[i]);
            exp_words[p].push_back(data[i]);
        end
        exp_len[p].push_back(len);
        exp_bad[p].push_back(bad);
        pending[p] += len + 1;
        frames_sent++;
        hdr = '0;
        hdr[PRIO_LSB +: $bits(prio_t)]    = pr;
        hdr[CRC_LSB +: $bits(crc_t)]      = bad ? ~c : c;  // corrupted header crc
        hdr[COUNT_LSB +: $bits(wcount_t)] = wcount_t'(len);
        write_word(p, hdr);
        foreach (data[i]) begin
            write_word(p, data[i]);
        end
        tick();
        in_wr <= 1'b0;
    endtask

    task automatic random_frame();
        logic [31:0] r;
        int          p;
        int          len;
        rand_bits(PW, r);
        p = int'(r);
        rand_bits(4, r);
        len = int'(r[3:0]) + 1;
        while (pending[p] + len + 1 > QUEUE_DEPTH) begin
            tick();                             // queue would overflow
        end
        rand_bits(1, r);
        tick();
        sched_mode <= r[0];
        rand_bits(5, r);
        send_frame(p, len, prio_t'(r[1:0]), r[4:2] == 3'b000);
        repeat (int'(r[1:0])) tick();
    endtask

    //////////////////////////////////////////////////////////////////////
    // one frame per port held back, then released in one mode
    //////////////////////////////////////////////////////////////////////

    task automatic ordered_round(input bit mode);
        int          pr_of [NUM_PORTS];
        int          j;
        int          t;
        logic [31:0] r;
        for (int i = 0; i < NUM_PORTS; i++) begin
            pr_of[i] = i;
        end
        for (int i = NUM_PORTS - 1; i > 0; i--) begin
            rand_bits(PW, r);
            j        = int'(r) % (i + 1);
            t        = pr_of[i];
            pr_of[i] = pr_of[j];
            pr_of[j] = t;
        end
        tick();
        ready      <= 1'b0;
        sched_mode <= mode;
        for (int i = 0; i < NUM_PORTS; i++) begin
            rand_bits(4, r);
            send_frame(i, int'(r[3:0]) + 1, prio_t'(pr_of[i]), 1'b0);
        end
        if (mode) begin
            for (int k = 1; k <= NUM_PORTS; k++) begin
                order_q.push_back((last_served + k) % NUM_PORTS);
            end
        end else begin
            for (int v = NUM_PORTS - 1; v >= 0; v--) begin
                for (int i = 0; i < NUM_PORTS; i++) begin
                    if (pr_of[i] == v) begin
                        order_q.push_back(i);
                    end
                end
            end
        end
        last_served = order_q[$];
        repeat (200) tick();
        ready <= 1'b1;
        // last verdict still to be sampled
        while (frames_done != frames_sent || err_window) begin
            tick();
        end
    endtask

    task automatic check_word();
        int    p;
        word_t exp;
        p = int'(out_port);
        if (!in_frame) begin
            assert (out_sop) else fail_check("first word of a frame without out_sop");
            assert (exp_len[p].size() > 0) else fail_check("frame on an idle port");
            if (order_q.size() > 0) begin
                assert (p == order_q[0])
                    else fail_check($sformatf("port %0d served, expected %0d", p, order_q[0]));
                void'(order_q.pop_front());
            end
            frame_port = p;
            words_left = exp_len[p][0];
            in_frame   = 1'b1;
        end else begin
            assert (!out_sop) else fail_check("out_sop inside a frame");
            assert (p == frame_port) else fail_check("out_port changed inside a frame");
        end
        exp = exp_words[p].pop_front();
        assert (out_data == exp)
            else fail_check($sformatf("port %0d data %h, expected %h", p, out_data, exp));
        assert (out_eop == (words_left == 1)) else fail_check("out_eop on the wrong word");
        words_left--;
        if (out_eop) begin
            err_due    = exp_bad[p].pop_front();
            err_window = 1'b1;
            pending[p] -= exp_len[p].pop_front() + 1;
            in_frame   = 1'b0;
            frames_done++;
        end
    endtask

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            low_run = ready ? 0 : low_run + 1;
            assert (!(low_run >= 2 && out_vld))
                else fail_check("word delivered after ready stayed low");
            if (err_window) begin
                assert (frame_err == err_due)
                    else fail_check($sformatf("frame_err %0b, expected %0b", frame_err, err_due));
                err_window = 1'b0;
            end else begin
                assert (!frame_err) else fail_check("frame_err away from end of frame");
            end
            if (out_vld) begin
                check_word();
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: %0d of %0d frames delivered", frames_done, frames_sent);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_wr      = 1'b0;
        in_port    = '0;
        in_data    = '0;
        sched_mode = 1'b0;
        ready      = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        ready <= 1'b1;
        @(negedge clk);
        assert (!out_vld && !out_sop && !out_eop && !frame_err)
            else fail_check("outputs not idle after reset");

        // mixed traffic with random back-pressure and some bad crc
        toggle_ready = 1'b1;
        for (int n = 0; n < N_RAND; n++) begin
            random_frame();
        end
        while (frames_done != frames_sent) begin
            tick();
        end
        toggle_ready = 1'b0;

        ordered_round(1'b0);    // strict priority
        ordered_round(1'b1);    // round robin

        if (errors == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "errors found");
        end
    end

endmodule

// ==== sim/egress_sva.sv ====
module egress_sva #(
    parameter int NUM_PORTS = 4
) (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         rd_en,
    input logic [$clog2(NUM_PORTS)-1:0] rd_sel,
    input logic [NUM_PORTS-1:0]         empty,
    input logic                         arb_en,
    input logic                         grant_vld,
    input logic                         out_vld,
    input logic                         out_sop,
    input logic                         out_eop,
    input logic                         frame_err
);
    timeunit 1ns;
    timeprecision 100ps;

    rd_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !empty[rd_sel])
        else $error("queue read issued for an empty port");

    marks_with_vld: assert property (@(posedge clk) disable iff (!rst_n)
        (out_sop || out_eop) |-> out_vld)
        else $error("frame marker without a valid word");

    // grant exactly one cycle after the request pulse
    grant_after_arb: assert property (@(posedge clk) disable iff (!rst_n)
        arb_en |=> grant_vld)
        else $error("no grant one cycle after arbitration request");

    grant_only_after_arb: assert property (@(posedge clk) disable iff (!rst_n)
        grant_vld |-> $past(arb_en))
        else $error("grant without a preceding arbitration request");

    err_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
        frame_err |-> $past(out_eop))
        else $error("frame error pulse not on the cycle after end of frame");

endmodule

bind egress_scheduler egress_sva #(.NUM_PORTS(NUM_PORTS)) u_sva (
    .clk, .rst_n,
    .rd_en(q.rd_en), .rd_sel(q.rd_sel), .empty(q.empty),
    .arb_en(a.arb_en), .grant_vld(a.grant_vld),
    .out_vld, .out_sop, .out_eop, .frame_err
);

// ==== design/egress_top.sv ====
module egress_top import egress_pkg::*; #(
    parameter int NUM_PORTS   = 4,
    parameter int QUEUE_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_wr,
    input  logic [$clog2(NUM_PORTS)-1:0] in_port,
    input  word_t                        in_data,
    input  logic                         sched_mode,
    input  logic                         ready,
    output word_t                        out_data,
    output logic                         out_vld,
    output logic                         out_sop,
    output logic                         out_eop,
    output logic [$clog2(NUM_PORTS)-1:0] out_port,
    output logic                         frame_err
);

    logic  crc_clear;
    logic  crc_enable;
    word_t crc_data;
    crc_t  crc_val;

    queue_rd_if #(.NUM_PORTS(NUM_PORTS)) qrd ();
    arb_if      #(.NUM_PORTS(NUM_PORTS)) arb ();

    frame_queue_bank #(
        .NUM_PORTS  (NUM_PORTS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queues (
        .clk, .rst_n, .in_wr, .in_port, .in_data,
        .q(qrd)
    );

    port_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arb (
        .clk, .rst_n, .sched_mode,
        .a(arb)
    );

    crc32_accum u_crc (
        .clk, .rst_n,
        .clear (crc_clear),
        .enable(crc_enable),
        .data  (crc_data),
        .crc   (crc_val)
    );

    egress_scheduler #(.NUM_PORTS(NUM_PORTS)) u_sched (
        .clk, .rst_n, .ready,
        .q(qrd), .a(arb),
        .crc_clear, .crc_enable, .crc_data,
        .crc(crc_val),
        .out_data, .out_vld, .out_sop, .out_eop, .out_port, .frame_err
    );

endmodule

// ==== design/egress_scheduler.sv ====
module egress_scheduler import egress_pkg::*; #(
    parameter int NUM_PORTS = 4
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ready,
    queue_rd_if.sched                    q,
    arb_if.sched                         a,
    output logic                         crc_clear,
    output logic                         crc_enable,
    output word_t                        crc_data,
    input  crc_t                         crc,
    output word_t                        out_data,
    output logic                         out_vld,
    output logic                         out_sop,
    output logic                         out_eop,
    output logic [$clog2(NUM_PORTS)-1:0] out_port,
    output logic                         frame_err
);

    localparam int PW = $clog2(NUM_PORTS);

    sched_state_t state;

    logic [PW-1:0]        scan_idx;
    logic [PW-1:0]        cur_port;    // granted port, held for the frame
    logic [NUM_PORTS-1:0] loaded;      // header slot in use
    logic                 first_word;  // next read is the first of the frame

    // header fields per port
    prio_t   hdr_prio [NUM_PORTS];
    crc_t    hdr_crc  [NUM_PORTS];
    wcount_t cnt      [NUM_PORTS];     // data words still to read

    logic need_load;
    logic scan_rd;
    logic send_rd;

    //////////////////////////////////////////////////////////////////////
    // read and arbitration strobes
    //////////////////////////////////////////////////////////////////////

    assign need_load = !q.empty[scan_idx] && !loaded[scan_idx];
    assign scan_rd   = (state == ST_SCAN) && need_load;

    // reads pause on back-pressure or a gap in the queue
    assign send_rd = (state == ST_SEND) && ready && !q.empty[cur_port]
                     && (cnt[cur_port] != '0);

    assign q.rd_en  = scan_rd || send_rd;
    assign q.rd_sel = (state == ST_SEND) ? cur_port : scan_idx;

    // header loading wins over starting a new frame
    assign a.arb_en = (state == ST_SCAN) && !need_load && ready && (|loaded);
    assign a.req    = loaded;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            a.prio[i] = hdr_prio[i];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output path and crc check
    //////////////////////////////////////////////////////////////////////

    assign out_data   = q.rd_data;       // head register of the queue bank
    assign out_port   = cur_port;
    assign crc_clear  = (state == ST_ARB);
    assign crc_enable = out_vld;         // every delivered word
    assign crc_data   = q.rd_data;

    // crc settles the cycle after out_eop
    assign frame_err = (state == ST_CHECK) && (crc != hdr_crc[cur_port]);

    //////////////////////////////////////////////////////////////////////
    // control FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_SCAN;
            scan_idx   <= '0;
            cur_port   <= '0;
            loaded     <= '0;
            first_word <= 1'b0;
            out_vld    <= 1'b0;
            out_sop    <= 1'b0;
            out_eop    <= 1'b0;
        end else begin
            out_vld <= send_rd;
            out_sop <= send_rd && first_word;
            out_eop <= send_rd && (cnt[cur_port] == wcount_t'(1));
            if (send_rd) begin
                first_word <= 1'b0;
            end

            case (state)
                ST_SCAN: begin
                    if (scan_rd) begin
                        state <= ST_HDR;       // hold scan_idx for capture
                    end else begin
                        scan_idx <= scan_idx + 1'b1;
                        if (a.arb_en) begin
                            state <= ST_ARB;
                        end
                    end
                end
                ST_HDR: begin
                    loaded[scan_idx] <= 1'b1;
                    scan_idx         <= scan_idx + 1'b1;
                    state            <= ST_SCAN;
                end
                ST_ARB: begin
                    if (a.grant_vld) begin
                        cur_port   <= a.grant;
                        first_word <= 1'b1;
                        state      <= ST_SEND;
                    end else begin
                        state <= ST_SCAN;
                    end
                end
                ST_SEND: begin
                    // last word leaves this cycle, verdict next
                    if (out_eop) begin
                        state <= ST_CHECK;
                    end
                end
                ST_CHECK: begin
                    loaded[cur_port] <= 1'b0;  // next frame header may load
                    state            <= ST_SCAN;
                end
                default: state <= ST_SCAN;
            endcase
        end
    end

    // header capture and word countdown
    always_ff @(posedge clk) begin
        if (state == ST_HDR) begin
            hdr_prio[scan_idx] <= q.rd_data[PRIO_LSB +: $bits(prio_t)];
            hdr_crc[scan_idx]  <= q.rd_data[CRC_LSB +: $bits(crc_t)];
            cnt[scan_idx]      <= q.rd_data[COUNT_LSB +: $bits(wcount_t)];
        end
        if (send_rd) begin
            cnt[cur_port] <= cnt[cur_port] - 1'b1;
        end
    end

endmodule

// ==== design/crc32_accum.sv ====
module crc32_accum import egress_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,   // restart at all ones
    input  logic  enable,  // fold data this cycle
    input  word_t data,
    output crc_t  crc
);

    // one word through the reflected lfsr, bit 0 first
    function automatic crc_t crc_fold(crc_t seed, word_t d);
        crc_t c;
        c = seed;
        for (int i = 0; i < $bits(word_t); i++) begin
            if (c[0] ^ d[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc <= CRC_INIT;
        end else if (enable) begin
            // clear with enable folds into a fresh seed
            crc <= crc_fold(clear ? CRC_INIT : crc, data);
        end else if (clear) begin
            crc <= CRC_INIT;
        end
    end

endmodule

// ==== design/port_arbiter.sv ====
module port_arbiter import egress_pkg::*; #(
    parameter int NUM_PORTS = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic sched_mode,  // 0 strict priority, 1 round robin
    arb_if.arb   a
);

    localparam int PW = $clog2(NUM_PORTS);

    logic [PW-1:0] last_ptr;   // last granted port
    logic [PW-1:0] prio_pick;
    logic [PW-1:0] rr_pick;
    logic [PW-1:0] rr_idx;
    logic [PW-1:0] pick;
    prio_t         best_prio;
    logic          prio_found;
    logic          rr_found;
    logic          any_req;

    assign any_req = |a.req;

    //////////////////////////////////////////////////////////////////////
    // strict priority, ties to lowest index
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        prio_pick  = '0;
        best_prio  = '0;
        prio_found = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            // strict greater keeps the earlier index on a tie
            if (a.req[i] && (!prio_found || a.prio[i] > best_prio)) begin
                prio_pick  = PW'(i);
                best_prio  = a.prio[i];
                prio_found = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // round robin, first requester after last_ptr
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rr_pick  = last_ptr;
        rr_found = 1'b0;
        rr_idx   = last_ptr;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            rr_idx = last_ptr + PW'(k);  // wraps, power-of-two ports
            if (!rr_found && a.req[rr_idx]) begin
                rr_pick  = rr_idx;
                rr_found = 1'b1;
            end
        end
    end

    assign pick = sched_mode ? rr_pick : prio_pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a.grant     <= '0;
            a.grant_vld <= 1'b0;
            last_ptr    <= PW'(NUM_PORTS - 1);  // port 0 goes first
        end else begin
            a.grant_vld <= a.arb_en && any_req;
            if (a.arb_en && any_req) begin
                a.grant  <= pick;
                last_ptr <= pick;
            end
        end
    end

endmodule

// ==== design/frame_queue_bank.sv ====
module frame_queue_bank import egress_pkg::*; #(
    parameter int NUM_PORTS   = 4,
    parameter int QUEUE_DEPTH = 64
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_wr,
    input  logic [$clog2(NUM_PORTS)-1:0] in_port,
    input  word_t                        in_data,
    queue_rd_if.queue                    q
);

    localparam int PW = $clog2(NUM_PORTS);
    localparam int AW = $clog2(QUEUE_DEPTH);
    localparam int CW = $clog2(QUEUE_DEPTH + 1);

    word_t          mem    [NUM_PORTS][QUEUE_DEPTH];
    logic  [AW-1:0] wr_ptr [NUM_PORTS];
    logic  [AW-1:0] rd_ptr [NUM_PORTS];
    logic  [CW-1:0] count  [NUM_PORTS];

    logic [NUM_PORTS-1:0] wr_hit;
    logic [NUM_PORTS-1:0] rd_hit;

    //////////////////////////////////////////////////////////////////////
    // per-port strobes and empty flags
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            wr_hit[i]  = in_wr && (in_port == PW'(i));
            rd_hit[i]  = q.rd_en && (q.rd_sel == PW'(i));
            q.empty[i] = (count[i] == '0);
        end
    end

    // storage and registered head word
    always_ff @(posedge clk) begin
        if (in_wr) begin
            mem[in_port][wr_ptr[in_port]] <= in_data;
        end
        if (q.rd_en) begin
            q.rd_data <= mem[q.rd_sel][rd_ptr[q.rd_sel]];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                count[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (wr_hit[i]) begin
                    wr_ptr[i] <= (wr_ptr[i] == AW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr[i] + 1'b1;
                end
                if (rd_hit[i]) begin
                    rd_ptr[i] <= (rd_ptr[i] == AW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr[i] + 1'b1;
                end
                // simultaneous push and pop leaves the count alone
                if (wr_hit[i] && !rd_hit[i]) begin
                    count[i] <= count[i] + 1'b1;
                end else if (rd_hit[i] && !wr_hit[i]) begin
                    count[i] <= count[i] - 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/egress_if.sv ====
// queue read side, scheduler to queue bank
interface queue_rd_if import egress_pkg::*; #(
    parameter int NUM_PORTS = 4
) ();
    localparam int PW = $clog2(NUM_PORTS);

    logic                 rd_en;
    logic [PW-1:0]        rd_sel;
    word_t                rd_data;  // head word, one cycle after rd_en
    logic [NUM_PORTS-1:0] empty;

    modport sched (output rd_en, rd_sel, input rd_data, empty);
    modport queue (input rd_en, rd_sel, output rd_data, empty);
endinterface

// arbitration request and grant
interface arb_if import egress_pkg::*; #(
    parameter int NUM_PORTS = 4
) ();
    localparam int PW = $clog2(NUM_PORTS);

    logic                 arb_en;     // one-cycle pulse
    logic [NUM_PORTS-1:0] req;        // ports holding a header
    prio_t                prio [NUM_PORTS];
    logic [PW-1:0]        grant;
    logic                 grant_vld;  // pulse, one cycle after arb_en

    modport sched (output arb_en, req, prio, input grant, grant_vld);
    modport arb   (input arb_en, req, prio, output grant, grant_vld);
endinterface

// ==== design/egress_pkg.sv ====
package egress_pkg;

    //////////////////////////////////////////////////////////////////////
    // word and field types
    //////////////////////////////////////////////////////////////////////

    typedef logic [47:0] word_t;    // queue and output word
    typedef logic [1:0]  prio_t;    // higher value wins
    typedef logic [31:0] crc_t;
    typedef logic [5:0]  wcount_t;  // data words per frame, 1..63

    // header word layout, upper bits zero
    localparam int PRIO_LSB  = 0;
    localparam int CRC_LSB   = 2;
    localparam int COUNT_LSB = 34;

    // reflected crc-32, lsb first over each word
    localparam crc_t CRC_POLY = 32'hEDB8_8320;
    localparam crc_t CRC_INIT = 32'hFFFF_FFFF;  // no final inversion

    //////////////////////////////////////////////////////////////////////
    // scheduler states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ST_SCAN,   // walk ports, load headers
        ST_HDR,    // header word on rd_data
        ST_ARB,    // grant arrives
        ST_SEND,   // stream granted frame
        ST_CHECK   // crc verdict, free slot
    } sched_state_t;

endpackage
